// File: tb.f
+incdir+src
src/ooo_pkg.sv
src/instruction_queue.sv
src/decode.sv
src/register_file.sv
src/reservation_station.sv
src/alu.sv
src/ooo_core.sv
tests/ooo_core_asserts.sv
tests/ooo_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := ooo_core_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/ooo_core_tb.sv
`include "ooo_settings.svh"

module ooo_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ooo_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 5;
  localparam int RANDOM_INST    = 300;
  localparam int BURST_INST     = 100;
  localparam int NUM_INST       = RANDOM_INST + BURST_INST;
  localparam int TIMEOUT_CYCLES = NUM_INST * 20 + 200;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
  } result_t;

  logic                 clk_in;
  logic                 reset;
  logic                 inst_valid;
  logic [31:0]          inst;
  logic                 inst_ready;
  cdb_t                 cdb;
  logic                 busy;
  logic [4:0]           dbg_addr;
  logic [`OOO_XLEN-1:0] dbg_data;

  logic [31:0] rng_state = 32'h9fd8;
  logic [31:0] model_regs [32];  // in-order architectural state
  result_t     outstanding [$];  // accepted results not yet broadcast
  int          expected_bcasts = 0;
  int          bcast_count = 0;
  logic        saw_full = 1'b0;

  ooo_core dut (
    .clk_in     (clk_in),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .cdb        (cdb),
    .busy       (busy),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_in);
    $display("Timeout: the core did not drain within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  // one broadcast lasts exactly one cycle
  always @(negedge clk_in) begin
    if (!reset && cdb.valid) begin
      bcast_count++;
      match_broadcast(cdb.rd, cdb.value);
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state ^ (rng_state >> 16);  // low lcg bits are weak
  endfunction

  // chain forces rd = rs1 = x1 so each instruction waits on the last
  function automatic logic [31:0] make_inst(input logic [31:0] r, input logic [31:0] s,
                                            input logic chain);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  other;
    rd    = chain ? 5'd1 : {2'b00, s[2:0]};
    rs1   = chain ? 5'd1 : {2'b00, s[5:3]};
    rs2   = {2'b00, s[8:6]};
    f3    = r[6:4];
    alt   = r[7] && (f3 == 3'b101 || (f3 == 3'b000 && r[1:0] == 2'd0));
    imm   = (f3[1:0] == 2'b01) ? {1'b0, alt, 5'b0, s[13:9]} : s[20:9];
    other = (r[9:8] == 2'd0) ? 7'b0000011 :
            (r[9:8] == 2'd1) ? 7'b0100011 :
            (r[9:8] == 2'd2) ? 7'b1100011 : 7'b1101111;
    case (r[1:0])
      2'd0:    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      2'd1:    return {imm, rs1, f3, rd, 7'b0010011};
      2'd2:    return {s[31:12], rd, 7'b0110111};
      default: return {s[31:7], other};  // load, store, branch, jal
    endcase
  endfunction

  task automatic model_exec(input logic [31:0] i);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    opc = i[6:0];
    f3  = i[14:12];
    a   = model_regs[i[19:15]];
    b   = (opc == 7'b0110011) ? model_regs[i[24:20]] : {{20{i[31]}}, i[31:20]};
    if (opc == 7'b0110111) begin
      res = {i[31:12], 12'b0};
    end else if (opc == 7'b0110011 || opc == 7'b0010011) begin
      case (f3)
        3'b000:  res = (opc == 7'b0110011 && i[30]) ? a - b : a + b;
        3'b001:  res = a << b[4:0];
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  res = (a < b) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ b;
        3'b101: begin
          if (i[30]) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        3'b110:  res = a | b;
        default: res = a & b;
      endcase
    end else begin
      return;  // not executed
    end
    expected_bcasts++;
    outstanding.push_back(result_t'{rd: i[11:7], value: res});
    if (i[11:7] != 5'd0) model_regs[i[11:7]] = res;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // results may broadcast out of order, any outstanding match is taken
  task automatic match_broadcast(input logic [4:0] rd, input logic [31:0] value);
    int hit;
    hit = -1;
    for (int k = 0; k < outstanding.size(); k++) begin
      if (hit < 0 && outstanding[k].rd == rd && outstanding[k].value == value) hit = k;
    end
    if (hit < 0) begin
      $display("Error at %0t: cdb broadcast of %h to x%0d matches no accepted instruction",
               $time, value, rd);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end else begin
      outstanding.delete(hit);
    end
  endtask

  // valid is held until the handshake completes
  task automatic drive_stream(input int count, input logic burst);
    int          sent;
    logic        taken;
    logic [31:0] r;
    sent  = 0;
    taken = 1'b0;
    while (sent < count) begin
      @(posedge clk_in);
      #DRIVE_DELAY;
      if (taken) inst_valid = 1'b0;
      if (!inst_valid) begin
        r = next_rand();
        if (burst || r[2:0] > 3'd2) begin
          inst       = make_inst(next_rand(), next_rand(), burst);
          inst_valid = 1'b1;
        end
      end
      @(negedge clk_in);
      if (!inst_ready) saw_full = 1'b1;
      taken = inst_valid && inst_ready;  // accepted at the coming edge
      if (taken) begin
        model_exec(inst);
        sent++;
      end
    end
    @(posedge clk_in);
    #DRIVE_DELAY;
    inst_valid = 1'b0;
  endtask

  task automatic check_registers();
    for (int i = 0; i < 32; i++) begin
      @(posedge clk_in);
      #DRIVE_DELAY;
      dbg_addr = 5'(i);
      @(negedge clk_in);
      compare($sformatf("dbg_data x%0d", i), dbg_data, model_regs[i]);
    end
  endtask

  initial begin
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    dbg_addr   = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk_in);
    compare("inst_ready", 32'(inst_ready), 32'd1);
    compare("busy", 32'(busy), 32'd0);
    compare("cdb.valid", 32'(cdb.valid), 32'd0);

    drive_stream(RANDOM_INST, 1'b0);
    drive_stream(BURST_INST, 1'b1);  // dependent chain back to back
    @(negedge clk_in);
    while (busy) @(negedge clk_in);

    compare("cdb broadcasts", 32'(bcast_count), 32'(expected_bcasts));
    compare("inst_ready seen low", 32'(saw_full), 32'd1);
    check_registers();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tests/ooo_core_asserts.sv
`include "ooo_settings.svh"

module ooo_core_asserts (
  input logic          clk_in,
  input logic          reset,
  input logic          inst_valid,
  input logic          inst_ready,
  input logic          dispatch,
  input ooo_pkg::cdb_t cdb
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IQ_DEPTH = `OOO_IQ_DEPTH;

  int iq_level;  // queue occupancy rebuilt from handshakes and pops

  always_ff @(posedge clk_in) begin
    if (reset) iq_level <= 0;
    else iq_level <= iq_level + int'(inst_valid && inst_ready) - int'(dispatch);
  end

  // an entry is freed at issue and needs a cycle before it can issue again
  cdb_tag_not_repeated: assert property (@(posedge clk_in) disable iff (reset)
    (cdb.valid && $past(cdb.valid)) |-> (cdb.tag != $past(cdb.tag)))
    else $error("cdb broadcast with tag %0d two cycles in a row", cdb.tag);

  // a full queue is the only back-pressure
  full_blocks_input: assert property (@(posedge clk_in) disable iff (reset)
    inst_ready == (iq_level < IQ_DEPTH))
    else $error("inst_ready is %0b with %0d instructions queued", inst_ready, iq_level);

  cdb_quiet_after_reset: assert property (@(posedge clk_in)
    $fell(reset) |-> !cdb.valid)
    else $error("cdb valid in the first cycle after reset");

endmodule

bind ooo_core ooo_core_asserts u_asserts (
  .clk_in     (clk_in),
  .reset      (reset),
  .inst_valid (inst_valid),
  .inst_ready (inst_ready),
  .dispatch   (dispatch),
  .cdb        (cdb)
);

// File: src/ooo_core.sv
`include "ooo_settings.svh"

module ooo_core (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 inst_valid,
  input  logic [31:0]          inst,
  output logic                 inst_ready,
  output ooo_pkg::cdb_t        cdb,
  output logic                 busy,
  input  logic [4:0]           dbg_addr,
  output logic [`OOO_XLEN-1:0] dbg_data
);
  import ooo_pkg::*;

  logic [31:0]          iq_head;
  logic                 iq_empty;
  logic                 iq_full;
  decoded_t             dec;
  operand_t             rf_op1;
  operand_t             rf_op2;
  operand_t             rs_op2;
  tag_t                 free_tag;
  logic                 has_free;
  logic                 dispatch;
  logic                 alloc;
  logic                 use_imm;
  logic                 issue;
  tag_t                 issue_tag;
  logic [4:0]           issue_rd;
  alu_func_e            issue_func;
  logic [`OOO_XLEN-1:0] issue_a;
  logic [`OOO_XLEN-1:0] issue_b;
  logic                 rs_occupied;

  assign inst_ready = !iq_full;

  // nops leave the queue without a station entry
  assign dispatch = !iq_empty && (dec.itype == NOP || has_free);
  assign alloc    = dispatch && dec.itype != NOP;
  assign use_imm  = (dec.itype == OPIMM) || (dec.itype == LUI);
  assign rs_op2   = use_imm ? operand_t'{ready: 1'b1, tag: '0, value: dec.imm} : rf_op2;

  assign busy = !iq_empty || rs_occupied || cdb.valid;

  instruction_queue u_iq (
    .clk_in (clk_in),
    .reset  (reset),
    .push   (inst_valid),
    .din    (inst),
    .pop    (dispatch),
    .dout   (iq_head),
    .empty  (iq_empty),
    .full   (iq_full)
  );

  decode u_decode (
    .inst (iq_head),
    .dec  (dec)
  );

  register_file u_rf (
    .clk_in     (clk_in),
    .reset      (reset),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .op1        (rf_op1),
    .op2        (rf_op2),
    .rename_en  (alloc),
    .rename_rd  (dec.rd),
    .rename_tag (free_tag),
    .cdb        (cdb),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data)
  );

  reservation_station u_rs (
    .clk_in     (clk_in),
    .reset      (reset),
    .alloc      (alloc),
    .alloc_func (dec.alu_func),
    .alloc_rd   (dec.rd),
    .alloc_op1  (rf_op1),
    .alloc_op2  (rs_op2),
    .free_tag   (free_tag),
    .has_free   (has_free),
    .cdb        (cdb),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .issue_rd   (issue_rd),
    .issue_func (issue_func),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .occupied   (rs_occupied)
  );

  alu u_alu (
    .clk_in     (clk_in),
    .reset      (reset),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .issue_rd   (issue_rd),
    .issue_func (issue_func),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .cdb        (cdb)
  );

endmodule

// File: src/alu.sv
`include "ooo_settings.svh"

module alu (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 issue,
  input  ooo_pkg::tag_t        issue_tag,
  input  logic [4:0]           issue_rd,
  input  ooo_pkg::alu_func_e   issue_func,
  input  logic [`OOO_XLEN-1:0] issue_a,
  input  logic [`OOO_XLEN-1:0] issue_b,
  output ooo_pkg::cdb_t        cdb
);
  import ooo_pkg::*;

  logic [`OOO_XLEN-1:0] result;
  logic [4:0]           shamt;

  assign shamt = issue_b[4:0];  // shifts use low five bits

  always_comb begin
    case (issue_func)
      ALU_ADD:   result = issue_a + issue_b;
      ALU_SUB:   result = issue_a - issue_b;
      ALU_SLL:   result = issue_a << shamt;
      ALU_SLT:   result = {{(`OOO_XLEN - 1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
      ALU_SLTU:  result = {{(`OOO_XLEN - 1){1'b0}}, issue_a < issue_b};
      ALU_XOR:   result = issue_a ^ issue_b;
      ALU_SRL:   result = issue_a >> shamt;
      ALU_SRA:   result = $signed(issue_a) >>> shamt;
      ALU_OR:    result = issue_a | issue_b;
      ALU_AND:   result = issue_a & issue_b;
      ALU_PASSB: result = issue_b;
      default:   result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    cdb.tag   <= issue_tag;
    cdb.rd    <= issue_rd;
    cdb.value <= result;
    if (reset) cdb.valid <= 1'b0;
    else cdb.valid <= issue;  // one cycle pulse per issue
  end

endmodule

// File: src/reservation_station.sv
`include "ooo_settings.svh"

module reservation_station (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 alloc,
  input  ooo_pkg::alu_func_e   alloc_func,
  input  logic [4:0]           alloc_rd,
  input  ooo_pkg::operand_t    alloc_op1,
  input  ooo_pkg::operand_t    alloc_op2,
  output ooo_pkg::tag_t        free_tag,
  output logic                 has_free,
  input  ooo_pkg::cdb_t        cdb,
  output logic                 issue,
  output ooo_pkg::tag_t        issue_tag,
  output logic [4:0]           issue_rd,
  output ooo_pkg::alu_func_e   issue_func,
  output logic [`OOO_XLEN-1:0] issue_a,
  output logic [`OOO_XLEN-1:0] issue_b,
  output logic                 occupied
);
  import ooo_pkg::*;

  localparam int DEPTH = `OOO_RS_DEPTH;

  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] ready;
  alu_func_e        func [DEPTH];
  logic [4:0]       rd [DEPTH];
  operand_t         op1 [DEPTH];
  operand_t         op2 [DEPTH];

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready[i] = valid[i] && op1[i].ready && op2[i].ready;
    end
  end

  // descending scan so the lowest index wins
  always_comb begin
    has_free  = 1'b0;
    free_tag  = '0;
    issue     = 1'b0;
    issue_tag = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        has_free = 1'b1;
        free_tag = tag_t'(i);
      end
      if (ready[i]) begin
        issue     = 1'b1;
        issue_tag = tag_t'(i);
      end
    end
  end

  assign issue_rd   = rd[issue_tag];
  assign issue_func = func[issue_tag];
  assign issue_a    = op1[issue_tag].value;
  assign issue_b    = op2[issue_tag].value;
  assign occupied   = |valid;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (issue) valid[issue_tag] <= 1'b0;  // freed as it leaves for the alu
      if (alloc && has_free) valid[free_tag] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    // cdb snoop for waiting operands
    for (int i = 0; i < DEPTH; i++) begin
      if (cdb.valid && valid[i]) begin
        if (!op1[i].ready && op1[i].tag == cdb.tag) begin
          op1[i].ready <= 1'b1;
          op1[i].value <= cdb.value;
        end
        if (!op2[i].ready && op2[i].tag == cdb.tag) begin
          op2[i].ready <= 1'b1;
          op2[i].value <= cdb.value;
        end
      end
    end
    if (alloc && has_free) begin
      func[free_tag] <= alloc_func;
      rd[free_tag]   <= alloc_rd;
      op1[free_tag]  <= alloc_op1;  // already bypassed by the register file
      op2[free_tag]  <= alloc_op2;
    end
  end

endmodule

// File: src/register_file.sv
`include "ooo_settings.svh"

module register_file (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic [4:0]           rs1,
  input  logic [4:0]           rs2,
  output ooo_pkg::operand_t    op1,
  output ooo_pkg::operand_t    op2,
  input  logic                 rename_en,
  input  logic [4:0]           rename_rd,
  input  ooo_pkg::tag_t        rename_tag,
  input  ooo_pkg::cdb_t        cdb,
  input  logic [4:0]           dbg_addr,
  output logic [`OOO_XLEN-1:0] dbg_data
);
  import ooo_pkg::*;

  logic [`OOO_XLEN-1:0] regs [32];
  logic [31:0]          pending;  // register waits on a station entry
  tag_t                 tags [32];
  logic                 rename_ok;
  logic                 wb_ok;

  // read with bypass from the broadcast of this cycle
  function automatic operand_t read_port(input logic [4:0] addr,
                                         input logic [`OOO_XLEN-1:0] val,
                                         input logic waiting,
                                         input tag_t tg,
                                         input cdb_t bus);
    operand_t o;
    o.ready = 1'b1;
    o.tag   = '0;
    o.value = val;
    if (addr == 5'd0) begin
      o.value = '0;
    end else if (waiting) begin
      if (bus.valid && bus.tag == tg && bus.rd == addr) begin
        o.value = bus.value;
      end else begin
        o.ready = 1'b0;
        o.tag   = tg;
        o.value = '0;
      end
    end
    return o;
  endfunction

  assign op1 = read_port(rs1, regs[rs1], pending[rs1], tags[rs1], cdb);
  assign op2 = read_port(rs2, regs[rs2], pending[rs2], tags[rs2], cdb);
  assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

  assign rename_ok = rename_en && rename_rd != 5'd0;
  // an older result must not overwrite a newer rename
  assign wb_ok = cdb.valid && cdb.rd != 5'd0 && pending[cdb.rd] && tags[cdb.rd] == cdb.tag
                 && !(rename_ok && rename_rd == cdb.rd);

  always_ff @(posedge clk_in) begin
    if (reset) begin
      pending <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      if (wb_ok) begin
        regs[cdb.rd]    <= cdb.value;
        pending[cdb.rd] <= 1'b0;
      end
      if (rename_ok) begin
        pending[rename_rd] <= 1'b1;
        tags[rename_rd]    <= rename_tag;
      end
    end
  end

endmodule

// File: src/decode.sv
module decode (
  input  logic [31:0]       inst,
  output ooo_pkg::decoded_t dec
);
  import ooo_pkg::*;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_alt;     // bit 30 variant, sub or sra
  logic       alt_ok;
  logic       f7_ok;
  logic       is_shift;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  alu_func_e  base_func;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign f7_alt   = (funct7 == 7'b0100000);
  assign is_shift = (funct3[1:0] == 2'b01);
  assign alt_ok   = (funct3 == 3'b101) || (funct3 == 3'b000 && opcode == OPC_OP);
  assign f7_ok    = (funct7 == 7'b0000000) || (f7_alt && alt_ok);
  assign imm_i    = {{20{inst[31]}}, inst[31:20]};
  assign imm_u    = {inst[31:12], 12'b0};

  always_comb begin
    case (funct3)
      3'b000:  base_func = (f7_alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
      3'b001:  base_func = ALU_SLL;
      3'b010:  base_func = ALU_SLT;
      3'b011:  base_func = ALU_SLTU;
      3'b100:  base_func = ALU_XOR;
      3'b101:  base_func = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  base_func = ALU_OR;
      default: base_func = ALU_AND;
    endcase
  end

  always_comb begin
    dec.itype    = NOP;
    dec.alu_func = ALU_ADD;
    dec.rd       = '0;
    dec.rs1      = '0;
    dec.rs2      = '0;
    dec.imm      = '0;
    case (opcode)
      OPC_OP: if (f7_ok) begin
        dec.itype    = OP;
        dec.alu_func = base_func;
        dec.rd       = inst[11:7];
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
      end
      // funct7 only constrains the immediate shifts
      OPC_OPIMM: if (!is_shift || f7_ok) begin
        dec.itype    = OPIMM;
        dec.alu_func = base_func;
        dec.rd       = inst[11:7];
        dec.rs1      = inst[19:15];
        dec.imm      = imm_i;
      end
      OPC_LUI: begin
        dec.itype    = LUI;
        dec.alu_func = ALU_PASSB;
        dec.rd       = inst[11:7];
        dec.imm      = imm_u;  // rs1 stays x0
      end
      default: ;
    endcase
  end

endmodule

// File: src/instruction_queue.sv
`include "ooo_settings.svh"

module instruction_queue (
  input  logic        clk_in,
  input  logic        reset,
  input  logic        push,
  input  logic [31:0] din,
  input  logic        pop,
  output logic [31:0] dout,
  output logic        empty,
  output logic        full
);

  localparam int DEPTH = `OOO_IQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [31:0]      mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (PTR_W + 1)'(DEPTH));
  assign do_push = push && !full;  // push on full is dropped
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];    // head falls through

  always_ff @(posedge clk_in) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

// File: src/ooo_pkg.sv
`include "ooo_settings.svh"

package ooo_pkg;

  localparam int TAG_W = $clog2(`OOO_RS_DEPTH);

  // index of the station entry that produces a value
  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    OP,
    OPIMM,
    LUI,
    NOP
  } itype_e;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    ALU_PASSB = 4'd10  // lui, result is operand b
  } alu_func_e;

  typedef struct packed {
    itype_e                itype;
    alu_func_e             alu_func;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [`OOO_XLEN-1:0]  imm;
  } decoded_t;

  // value is only meaningful when ready, otherwise wait on tag
  typedef struct packed {
    logic                  ready;
    tag_t                  tag;
    logic [`OOO_XLEN-1:0]  value;
  } operand_t;

  typedef struct packed {
    logic                  valid;
    tag_t                  tag;
    logic [4:0]            rd;
    logic [`OOO_XLEN-1:0]  value;
  } cdb_t;

endpackage

// File: src/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// instruction queue entries
`define OOO_IQ_DEPTH 4

// reservation station entries, also sets the tag width
`define OOO_RS_DEPTH 4

// datapath width
`define OOO_XLEN 32

`endif
